/* include/ifetch_defines.svh */
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// direct-mapped instruction cache, one 8-byte block per line
`define IFETCH_ICACHE_LINES 8

// memory transaction tags, tag 0 is reserved for "no transaction"
`define IFETCH_NUM_TAGS 16

// how many blocks the prefetch counter may lead delivery by
`define IFETCH_PREFETCH_DEPTH 2

// first delivery address after reset
`define IFETCH_RESET_PC 32'h0000_0000

`endif

/* verilog/ifetch_pkg.sv */
`include "ifetch_defines.svh"

package ifetch_pkg;

    // byte address, blocks are 8-byte aligned
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] inst_t;

    // fetch block: [31:0] holds the word at the block address,
    // [63:32] the word at block address + 4
    typedef logic [63:0] block_t;

    // tag handed out by memory on request acceptance
    typedef logic [$clog2(`IFETCH_NUM_TAGS)-1:0] mem_tag_t;

    // prefetch control states
    typedef enum logic [1:0] {
        st_fetch,
        st_prefetch,
        st_stall
    } fetch_state_e;

endpackage

/* verilog/fetch_fsm.sv */
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module fetch_fsm (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               br_en,
    input  logic               mshr_full,
    input  logic               probe_hit,
    input  logic               mem_handshake,
    input  ifetch_pkg::addr_t  deliver_addr,
    input  ifetch_pkg::addr_t  prefetch_addr,
    output logic               mem_en,
    output logic               pf_advance
);
    localparam int DEPTH = `IFETCH_PREFETCH_DEPTH;

    ifetch_pkg::fetch_state_e state, next_state;
    logic [28:0] lead;
    logic        window_full;
    logic        stall_cond;

    // prefetch lead in blocks, never negative since fetch_pc drags prefetch along
    assign lead        = prefetch_addr[31:3] - deliver_addr[31:3];
    assign window_full = (lead >= DEPTH);
    assign stall_cond  = mshr_full | window_full;

    // request only for blocks the cache does not already hold
    assign mem_en = (state == ifetch_pkg::st_prefetch) & ~stall_cond & ~probe_hit;

    // step past the block once it is requested or found resident
    assign pf_advance = (state == ifetch_pkg::st_prefetch) & ~stall_cond
                      & (probe_hit | mem_handshake);

    always_comb begin
        next_state = state;
        case (state)
            ifetch_pkg::st_fetch:    next_state = ifetch_pkg::st_prefetch;
            ifetch_pkg::st_prefetch: if (stall_cond) next_state = ifetch_pkg::st_stall;
            ifetch_pkg::st_stall:    if (!stall_cond) next_state = ifetch_pkg::st_prefetch;
            default:                 next_state = ifetch_pkg::st_fetch;
        endcase
        // a redirect restarts the sequence
        if (br_en) begin
            next_state = ifetch_pkg::st_fetch;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ifetch_pkg::st_fetch;
        end else begin
            state <= next_state;
        end
    end

    // prefetch never leads delivery by more than the window
    a_lead_in_window: assert property (
        @(posedge clock) disable iff (!rst_n) lead <= DEPTH
    );

endmodule

/* verilog/fetch_pc.sv */
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module fetch_pc (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               br_en,
    input  ifetch_pkg::addr_t  target,
    input  logic               pf_advance,
    input  logic               deliver_advance,
    output ifetch_pkg::addr_t  deliver_addr,
    output ifetch_pkg::addr_t  prefetch_addr
);
    localparam int LINES = `IFETCH_ICACHE_LINES;

    ifetch_pkg::addr_t        next_deliver;
    ifetch_pkg::addr_t        stepped_prefetch;
    ifetch_pkg::addr_t        next_prefetch;
    logic signed [28:0]       next_lead;
    logic signed [28:0]       lead;
    ifetch_pkg::fetch_state_e phase;

    always_comb begin
        next_deliver     = deliver_addr;
        stepped_prefetch = prefetch_addr;
        // delivery moves to the next block boundary, realigning a misaligned target
        if (deliver_advance) begin
            next_deliver = {deliver_addr[31:3] + 29'd1, 3'b000};
        end
        if (pf_advance) begin
            stepped_prefetch = prefetch_addr + 32'd8;
        end
        // cache hits right after a branch can let delivery pass prefetch
        next_lead     = stepped_prefetch[31:3] - next_deliver[31:3];
        next_prefetch = stepped_prefetch;
        if (next_lead < 0) begin
            next_prefetch = {next_deliver[31:3], 3'b000};
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            deliver_addr  <= `IFETCH_RESET_PC;
            prefetch_addr <= `IFETCH_RESET_PC;
        end else if (br_en) begin
            deliver_addr  <= target;
            prefetch_addr <= {target[31:3], 3'b000};
        end else begin
            deliver_addr  <= next_deliver;
            prefetch_addr <= next_prefetch;
        end
    end

    // st_fetch marks the first cycle on a new path
    always_ff @(posedge clock) begin
        if (!rst_n || br_en) begin
            phase <= ifetch_pkg::st_fetch;
        end else begin
            phase <= ifetch_pkg::st_prefetch;
        end
    end

    assign lead = prefetch_addr[31:3] - deliver_addr[31:3];

    // prefetch stays at or ahead of delivery, and within reach of the cache
    a_prefetch_lead: assert property (
        @(posedge clock) disable iff (!rst_n)
        (phase != ifetch_pkg::st_fetch) |-> (lead >= 0) && (lead < LINES)
    );

endmodule

/* verilog/mshr_table.sv */
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module mshr_table (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  mem_en,
    input  logic                  mem_handshake,
    input  ifetch_pkg::addr_t     mem_addr,
    input  ifetch_pkg::mem_tag_t  mem_transaction_tag,
    input  ifetch_pkg::mem_tag_t  mem_data_tag,
    input  ifetch_pkg::block_t    mem_data,
    output logic                  fill_en,
    output ifetch_pkg::addr_t     fill_addr,
    output ifetch_pkg::block_t    fill_data,
    output logic                  mshr_full
);
    localparam int TAGS = `IFETCH_NUM_TAGS;

    // one entry per tag, entry 0 never allocates
    logic [TAGS-1:0]   valid;
    ifetch_pkg::addr_t blk_addr [TAGS];

    logic accept;
    logic data_ret;

    assign accept   = mem_en & mem_handshake & (mem_transaction_tag != '0);
    assign data_ret = (mem_data_tag != '0);

    // fill is presented straight from the returning tag
    assign fill_en   = data_ret & valid[mem_data_tag];
    assign fill_addr = blk_addr[mem_data_tag];
    assign fill_data = mem_data;

    // tags 1..15 all busy
    assign mshr_full = &valid[TAGS-1:1];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            // free first, memory never reissues a tag that is still out
            if (fill_en) begin
                valid[mem_data_tag] <= 1'b0;
            end
            if (accept) begin
                valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    // block address recorded at acceptance
    always_ff @(posedge clock) begin
        if (accept) begin
            blk_addr[mem_transaction_tag] <= {mem_addr[31:3], 3'b000};
        end
    end

    // memory handed out a tag we still wait on
    a_alloc_free_tag: assert property (
        @(posedge clock) disable iff (!rst_n) accept |-> !valid[mem_transaction_tag]
    );

    // memory returned data for a tag never issued or already filled
    a_data_known_tag: assert property (
        @(posedge clock) disable iff (!rst_n) data_ret |-> valid[mem_data_tag]
    );

endmodule

/* verilog/icache.sv */
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module icache (
    input  logic                clock,
    input  logic                rst_n,
    input  ifetch_pkg::addr_t   deliver_addr,
    input  ifetch_pkg::addr_t   prefetch_addr,
    input  logic                fill_en,
    input  ifetch_pkg::addr_t   fill_addr,
    input  ifetch_pkg::block_t  fill_data,
    output logic                hit,
    output ifetch_pkg::block_t  hit_data,
    output logic                probe_hit
);
    localparam int LINES  = `IFETCH_ICACHE_LINES;
    localparam int IDX_W  = $clog2(LINES);
    localparam int TAG_W  = 32 - 3 - IDX_W;

    logic [LINES-1:0]   line_valid;
    logic [TAG_W-1:0]   line_tag  [LINES];
    ifetch_pkg::block_t line_data [LINES];

    // address split: tag | index | 3-bit byte offset
    logic [IDX_W-1:0] d_idx, p_idx, f_idx;
    logic [TAG_W-1:0] d_tag, p_tag, f_tag;

    assign d_idx = deliver_addr[3 +: IDX_W];
    assign d_tag = deliver_addr[31 -: TAG_W];
    assign p_idx = prefetch_addr[3 +: IDX_W];
    assign p_tag = prefetch_addr[31 -: TAG_W];
    assign f_idx = fill_addr[3 +: IDX_W];
    assign f_tag = fill_addr[31 -: TAG_W];

    // delivery read port
    assign hit      = line_valid[d_idx] & (line_tag[d_idx] == d_tag);
    assign hit_data = line_data[d_idx];

    // probe port, presence only
    assign probe_hit = line_valid[p_idx] & (line_tag[p_idx] == p_tag);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            line_valid <= '0;
        end else if (fill_en) begin
            line_valid[f_idx] <= 1'b1;
        end
    end

    // fill simply overwrites whatever the line held
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_tag[f_idx]  <= f_tag;
            line_data[f_idx] <= fill_data;
        end
    end

endmodule

/* verilog/inst_packer.sv */
`timescale 1ns/1ns

module inst_packer (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                br_en,
    input  logic                ibuff_open,
    input  ifetch_pkg::addr_t   deliver_addr,
    input  logic                hit,
    input  ifetch_pkg::block_t  hit_data,
    input  logic                fill_en,
    input  ifetch_pkg::addr_t   fill_addr,
    input  ifetch_pkg::block_t  fill_data,
    output logic                deliver_advance,
    output ifetch_pkg::addr_t   out_pc0,
    output ifetch_pkg::inst_t   out_inst0,
    output ifetch_pkg::addr_t   out_pc1,
    output ifetch_pkg::inst_t   out_inst1,
    output logic [1:0]          num_insts
);
    logic               fill_match;
    logic               avail;
    ifetch_pkg::block_t blk;
    ifetch_pkg::addr_t  blk_base;
    logic               upper_only;

    // a fill for the block we wait on bypasses the cache
    assign fill_match = fill_en & (fill_addr[31:3] == deliver_addr[31:3]);
    assign avail      = hit | fill_match;
    assign blk        = hit ? hit_data : fill_data;
    assign blk_base   = {deliver_addr[31:3], 3'b000};

    // misaligned entry, only the upper word is on the path
    assign upper_only = deliver_addr[2];

    assign deliver_advance = ibuff_open & avail & ~br_en;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            num_insts <= 2'd0;
        end else if (deliver_advance) begin
            num_insts <= upper_only ? 2'd1 : 2'd2;
        end else begin
            num_insts <= 2'd0;
        end
    end

    // slot 0 is the older instruction
    always_ff @(posedge clock) begin
        if (deliver_advance) begin
            out_pc0   <= upper_only ? (blk_base + 32'd4) : blk_base;
            out_inst0 <= upper_only ? blk[63:32] : blk[31:0];
            out_pc1   <= blk_base + 32'd4;
            out_inst1 <= blk[63:32];
        end
    end

endmodule

/* verilog/ifetch_top.sv */
`timescale 1ns/1ns

module ifetch_top (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  br_en,
    input  ifetch_pkg::addr_t     target,
    input  logic                  ibuff_open,
    input  logic                  mem_handshake,
    input  ifetch_pkg::mem_tag_t  mem_transaction_tag,
    input  ifetch_pkg::mem_tag_t  mem_data_tag,
    input  ifetch_pkg::block_t    mem_data,
    output logic                  mem_en,
    output ifetch_pkg::addr_t     mem_addr,
    output ifetch_pkg::addr_t     out_pc0,
    output ifetch_pkg::inst_t     out_inst0,
    output ifetch_pkg::addr_t     out_pc1,
    output ifetch_pkg::inst_t     out_inst1,
    output logic [1:0]            num_insts
);
    // mem_addr doubles as the prefetch counter
    ifetch_pkg::addr_t  deliver_addr;
    logic               pf_advance;
    logic               deliver_advance;
    logic               fill_en;
    ifetch_pkg::addr_t  fill_addr;
    ifetch_pkg::block_t fill_data;
    logic               mshr_full;
    logic               hit;
    ifetch_pkg::block_t hit_data;
    logic               probe_hit;

    fetch_fsm i_fetch_fsm (
        .clock         (clock),
        .rst_n         (rst_n),
        .br_en         (br_en),
        .mshr_full     (mshr_full),
        .probe_hit     (probe_hit),
        .mem_handshake (mem_handshake),
        .deliver_addr  (deliver_addr),
        .prefetch_addr (mem_addr),
        .mem_en        (mem_en),
        .pf_advance    (pf_advance)
    );

    fetch_pc i_fetch_pc (
        .clock           (clock),
        .rst_n           (rst_n),
        .br_en           (br_en),
        .target          (target),
        .pf_advance      (pf_advance),
        .deliver_advance (deliver_advance),
        .deliver_addr    (deliver_addr),
        .prefetch_addr   (mem_addr)
    );

    mshr_table i_mshr_table (
        .clock               (clock),
        .rst_n               (rst_n),
        .mem_en              (mem_en),
        .mem_handshake       (mem_handshake),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .fill_en             (fill_en),
        .fill_addr           (fill_addr),
        .fill_data           (fill_data),
        .mshr_full           (mshr_full)
    );

    icache i_icache (
        .clock         (clock),
        .rst_n         (rst_n),
        .deliver_addr  (deliver_addr),
        .prefetch_addr (mem_addr),
        .fill_en       (fill_en),
        .fill_addr     (fill_addr),
        .fill_data     (fill_data),
        .hit           (hit),
        .hit_data      (hit_data),
        .probe_hit     (probe_hit)
    );

    inst_packer i_inst_packer (
        .clock           (clock),
        .rst_n           (rst_n),
        .br_en           (br_en),
        .ibuff_open      (ibuff_open),
        .deliver_addr    (deliver_addr),
        .hit             (hit),
        .hit_data        (hit_data),
        .fill_en         (fill_en),
        .fill_addr       (fill_addr),
        .fill_data       (fill_data),
        .deliver_advance (deliver_advance),
        .out_pc0         (out_pc0),
        .out_inst0       (out_inst0),
        .out_pc1         (out_pc1),
        .out_inst1       (out_inst1),
        .num_insts       (num_insts)
    );

endmodule

/* verif/ifetch_tb.sv */
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_tb;
    localparam int MAX_WORDS = 256;
    localparam int MAX_EXP   = 64;
    localparam int MAX_BR    = 8;
    localparam int TIMEOUT   = 3000;

    logic                  clock;
    logic                  rst_n;
    logic                  br_en;
    ifetch_pkg::addr_t     target;
    logic                  ibuff_open;
    logic                  mem_handshake;
    ifetch_pkg::mem_tag_t  mem_transaction_tag;
    ifetch_pkg::mem_tag_t  mem_data_tag;
    ifetch_pkg::block_t    mem_data;
    logic                  mem_en;
    ifetch_pkg::addr_t     mem_addr;
    ifetch_pkg::addr_t     out_pc0;
    ifetch_pkg::inst_t     out_inst0;
    ifetch_pkg::addr_t     out_pc1;
    ifetch_pkg::inst_t     out_inst1;
    logic [1:0]            num_insts;

    // raw golden words and the records parsed from them
    logic [31:0]       golden [MAX_WORDS];
    logic [63:0]       image [logic [31:0]];
    ifetch_pkg::addr_t exp_pc [MAX_EXP];
    ifetch_pkg::inst_t exp_inst [MAX_EXP];
    int                exp_count;
    int                exp_idx;
    int                br_k [MAX_BR];
    ifetch_pkg::addr_t br_target [MAX_BR];
    int                br_count;
    int                br_idx;

    // tagged memory model state
    logic [15:0]       outstanding;
    ifetch_pkg::addr_t req_addr [16];
    int                due [16];
    logic [3:0]        ret_tag;
    int                cycle;

    // stream tracking
    int                delivered;
    ifetch_pkg::addr_t last_pc;
    logic              path_new;
    logic              expect_single;
    logic              br_prev;
    logic              in_loop;
    ifetch_pkg::addr_t loop_base;

    ifetch_top i_dut (
        .clock               (clock),
        .rst_n               (rst_n),
        .br_en               (br_en),
        .target              (target),
        .ibuff_open          (ibuff_open),
        .mem_handshake       (mem_handshake),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .out_pc0             (out_pc0),
        .out_inst0           (out_inst0),
        .out_pc1             (out_pc1),
        .out_inst1           (out_inst1),
        .num_insts           (num_insts)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected 0x%h got 0x%h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    // blocks missing from the image get an address-derived pattern
    function automatic ifetch_pkg::block_t mem_block(input ifetch_pkg::addr_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return {a ^ 32'h5a5a_0000, ~a};
    endfunction

    // record types: 1 image, 2 branch, 3 expected, 0 end
    task automatic load_golden();
        int pos;
        pos = 0;
        for (int i = 0; i < MAX_WORDS; i++) begin
            golden[i] = '0;
        end
        $readmemh("verif/ifetch_golden.txt", golden);
        while (pos < MAX_WORDS - 4 && golden[pos] != 0) begin
            case (golden[pos])
                32'd1: begin
                    image[golden[pos+1]] = {golden[pos+3], golden[pos+2]};
                    pos += 4;
                end
                32'd2: begin
                    br_k[br_count]      = int'(golden[pos+1]);
                    br_target[br_count] = golden[pos+2];
                    br_count++;
                    pos += 3;
                end
                32'd3: begin
                    exp_pc[exp_count]   = golden[pos+1];
                    exp_inst[exp_count] = golden[pos+2];
                    exp_count++;
                    pos += 3;
                end
                default: fail_run("golden file holds an unknown record type");
            endcase
        end
    endtask

    task automatic take_slot(input int slot, input ifetch_pkg::addr_t pc,
                             input ifetch_pkg::inst_t inst);
        if (exp_idx >= exp_count) begin
            fail_run("DUT delivered more instructions than the golden stream holds");
        end
        if (exp_idx == 0) begin
            check_value("out_pc0", `IFETCH_RESET_PC, pc);
        end
        // sequential code steps by one word
        if (!path_new) begin
            check_value($sformatf("out_pc%0d", slot), last_pc + 32'd4, pc);
        end
        check_value($sformatf("out_pc%0d", slot), exp_pc[exp_idx], pc);
        check_value($sformatf("out_inst%0d", slot), exp_inst[exp_idx], inst);
        last_pc  = pc;
        path_new = 1'b0;
        exp_idx++;
        delivered++;
    endtask

    task automatic collect_output();
        if (br_prev) begin
            check_value("num_insts", 0, num_insts);
        end
        if (num_insts > 2'd2) begin
            check_value("num_insts", 2, num_insts);
        end
        if (num_insts != 2'd0) begin
            // first group on a new path, single when the target is misaligned
            if (path_new && exp_idx > 0) begin
                check_value("num_insts", expect_single ? 1 : 2, num_insts);
            end
            take_slot(0, out_pc0, out_inst0);
            if (num_insts == 2'd2) begin
                take_slot(1, out_pc1, out_inst1);
            end
        end
    endtask

    task automatic steer_branch();
        br_en   = 1'b0;
        br_prev = 1'b0;
        if (br_idx < br_count) begin
            if (delivered > br_k[br_idx]) begin
                fail_run("delivery ran past a branch point");
            end
            if (delivered == br_k[br_idx]) begin
                br_en         = 1'b1;
                br_prev       = 1'b1;
                target        = br_target[br_idx];
                in_loop       = (br_target[br_idx] < last_pc);
                loop_base     = {br_target[br_idx][31:3], 3'b000};
                expect_single = br_target[br_idx][2];
                path_new      = 1'b1;
                br_idx++;
            end
        end
    endtask

    task automatic memory_return();
        // the tag returned last cycle was filled at the edge
        if (ret_tag != 0) begin
            outstanding[ret_tag] = 1'b0;
        end
        ret_tag = 0;
        for (int t = 1; t < 16; t++) begin
            if (ret_tag == 0 && outstanding[t] && due[t] <= cycle) begin
                ret_tag = 4'(t);
            end
        end
        mem_data_tag = ret_tag;
        mem_data     = (ret_tag != 0) ? mem_block(req_addr[ret_tag]) : '0;
    endtask

    task automatic memory_offer();
        int start;
        int t;
        logic [3:0] pick;
        pick  = 0;
        start = 1 + int'($urandom % 15);
        for (int i = 0; i < 15; i++) begin
            t = 1 + ((start - 1 + i) % 15);
            if (pick == 0 && !outstanding[t]) begin
                pick = 4'(t);
            end
        end
        if (pick != 0 && ($urandom % 4) != 0) begin
            mem_handshake       = 1'b1;
            mem_transaction_tag = pick;
        end else begin
            mem_handshake       = 1'b0;
            mem_transaction_tag = 0;
        end
    endtask

    task automatic memory_accept();
        // requests always name a whole block
        check_value("mem_addr[2:0]", 0, mem_addr[2:0]);
        if (mem_en && mem_handshake) begin
            if (in_loop && mem_addr >= loop_base && mem_addr < loop_base + 32'd32) begin
                fail_run($sformatf("loop block 0x%h was fetched again on its second pass",
                                   mem_addr));
            end
            outstanding[mem_transaction_tag] = 1'b1;
            req_addr[mem_transaction_tag]    = mem_addr;
            due[mem_transaction_tag]         = cycle + 1 + int'($urandom % 12);
        end
    endtask

    initial begin
        rst_n               = 1'b0;
        br_en               = 1'b0;
        target              = '0;
        ibuff_open          = 1'b0;
        mem_handshake       = 1'b0;
        mem_transaction_tag = '0;
        mem_data_tag        = '0;
        mem_data            = '0;
        outstanding         = '0;
        ret_tag             = 0;
        cycle               = 0;
        exp_count           = 0;
        exp_idx             = 0;
        br_count            = 0;
        br_idx              = 0;
        delivered           = 0;
        last_pc             = '0;
        path_new            = 1'b1;
        expect_single       = 1'b0;
        br_prev             = 1'b0;
        in_loop             = 1'b0;
        loop_base           = '0;
        void'($urandom(32'h096c3585));
        load_golden();
        if (exp_count == 0) begin
            fail_run("golden file holds no expected instructions");
        end

        // outputs stay quiet through reset
        repeat (3) begin
            @(negedge clock);
            check_value("mem_en", 0, mem_en);
            check_value("num_insts", 0, num_insts);
        end
        rst_n = 1'b1;

        while (exp_idx < exp_count) begin
            if (cycle >= TIMEOUT) begin
                fail_run("timed out waiting for the expected instruction stream");
            end
            @(negedge clock);
            cycle++;
            collect_output();
            steer_branch();
            ibuff_open = (($urandom % 3) != 0);
            memory_return();
            memory_offer();
            // request lines settle well before the next rising edge
            #1;
            memory_accept();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verif/ifetch_golden.txt */
// 1 block_addr lo_word hi_word : memory image, 2 count target : branch
// 3 pc inst : expected stream in order, 0 ends the file
1 00000000 13000000 13000004
1 00000008 13000008 1300000c
1 00000010 13000010 13000014
1 00000018 13000018 1300001c
1 00000040 13000040 13000044
1 00000048 13000048 1300004c
1 00000050 13000050 13000054
1 00000058 13000058 1300005c
2 00000008 00000044
2 0000000f 00000040
3 00000000 13000000  3 00000004 13000004  3 00000008 13000008
3 0000000c 1300000c  3 00000010 13000010  3 00000014 13000014
3 00000018 13000018  3 0000001c 1300001c
// misaligned entry into the loop
3 00000044 13000044  3 00000048 13000048  3 0000004c 1300004c
3 00000050 13000050  3 00000054 13000054  3 00000058 13000058
3 0000005c 1300005c
// second pass from the cache
3 00000040 13000040  3 00000044 13000044  3 00000048 13000048
3 0000004c 1300004c  3 00000050 13000050  3 00000054 13000054
3 00000058 13000058  3 0000005c 1300005c
0

/* ifetch.f */
+incdir+include
verilog/ifetch_pkg.sv
verilog/fetch_fsm.sv
verilog/fetch_pc.sv
verilog/mshr_table.sv
verilog/icache.sv
verilog/inst_packer.sv
verilog/ifetch_top.sv
verif/ifetch_tb.sv

/* Makefile */
TOP = ifetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f ifetch.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f ifetch.f --top-module $(TOP) -o ifetch_sim
	./obj_dir/ifetch_sim

clean:
	rm -rf obj_dir
